//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_blue8
FILELIST  ?= files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

//--- files.f
+incdir+include
source/blue8_pkg.sv
source/instr_decode.sv
source/cpu_control.sv
source/program_counter.sv
source/accum_datapath.sv
source/wb_bus_master.sv
source/blue8_core.sv
test/wb_memory_model.sv
test/tb_blue8.sv

//--- include/blue8_params.svh
`ifndef BLUE8_PARAMS_SVH
`define BLUE8_PARAMS_SVH

// data and instruction word width
`define B8_DATA_W 16

// word address width, 4k words
`define B8_ADDR_W 12

`define B8_RESET_PC 0  // first fetch address

`endif

//--- source/accum_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module accum_datapath
    import blue8_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`B8_DATA_W-1:0] rd_data,
    input  logic                  ir_load,
    input  logic                  operand_load,
    input  logic                  acc_write,
    input  alu_op_e               alu_op,
    output logic [`B8_DATA_W-1:0] instr,
    output logic [`B8_DATA_W-1:0] acc,
    output logic                  acc_neg
);

    logic [`B8_DATA_W-1:0] operand;     // memory word for the alu
    logic [`B8_DATA_W-1:0] alu_result;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = acc + operand;  // mod 2^16, no carry kept
            ALU_SUB: alu_result = acc - operand;
            ALU_XOR: alu_result = acc ^ operand;
            ALU_AND: alu_result = acc & operand;
            ALU_IOR: alu_result = acc | operand;
            ALU_NOT: alu_result = ~acc;
            ALU_INC: alu_result = acc + 1'b1;
            ALU_DEC: alu_result = acc - 1'b1;
            default: alu_result = operand;  // pass, lda
        endcase
    end

    always_ff @(posedge clk) begin
        if (ir_load) instr <= rd_data;          // fetched word
        if (operand_load) operand <= rd_data;   // operand read
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_write) begin
            acc <= alu_result;
        end
    end

    assign acc_neg = acc[`B8_DATA_W-1];  // sign for skip

endmodule

`default_nettype wire

//--- source/blue8_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module blue8_core
    import blue8_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output wb_req_t               wb_out,
    input  wb_rsp_t               wb_in,
    output logic                  halted,
    output logic [`B8_DATA_W-1:0] acc
);

    instr_dec_t            dec;
    alu_op_e               alu_op;
    logic [`B8_DATA_W-1:0] instr;
    logic [`B8_DATA_W-1:0] rd_data;
    logic [`B8_ADDR_W-1:0] pc;
    logic [`B8_ADDR_W-1:0] bus_adr;  // fetch or operand address
    logic                  acc_neg;
    logic                  bus_start, bus_we, bus_use_operand, bus_done;
    logic                  ir_load, operand_load, acc_write;
    logic                  pc_inc, pc_load;

    assign bus_adr = bus_use_operand ? dec.operand : pc;

    instr_decode u_decode (.instr(instr), .dec(dec));

    cpu_control u_control (
        .clk(clk), .reset(reset), .dec(dec), .acc_neg(acc_neg), .bus_done(bus_done),
        .bus_start(bus_start), .bus_we(bus_we), .bus_use_operand(bus_use_operand),
        .ir_load(ir_load), .operand_load(operand_load), .acc_write(acc_write),
        .alu_op(alu_op), .pc_inc(pc_inc), .pc_load(pc_load), .halted(halted)
    );

    program_counter u_pc (
        .clk(clk), .reset(reset), .inc(pc_inc), .load(pc_load),
        .target(dec.operand), .pc(pc)  // jump target straight from decode
    );

    accum_datapath u_datapath (
        .clk(clk), .reset(reset), .rd_data(rd_data), .ir_load(ir_load),
        .operand_load(operand_load), .acc_write(acc_write), .alu_op(alu_op),
        .instr(instr), .acc(acc), .acc_neg(acc_neg)
    );

    wb_bus_master u_bus (
        .clk(clk), .reset(reset), .start(bus_start), .we(bus_we), .adr(bus_adr),
        .wdata(acc), .wb_out(wb_out), .wb_in(wb_in), .done(bus_done), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- source/blue8_pkg.sv
`default_nettype none

package blue8_pkg;

`include "blue8_params.svh"

    // one flag per operation, at most one set
    typedef struct packed {
        logic op_halt;
        logic op_nop;
        logic op_not;
        logic op_inc;
        logic op_dec;
        logic op_spn;   // skip on sign
        logic op_add;
        logic op_xor;
        logic op_and;
        logic op_ior;
        logic op_sub;
        logic op_lda;
        logic op_sta;
        logic op_jmp;
        logic [`B8_ADDR_W-1:0] operand;  // low 12 bits of the word
        logic skip_neg;                  // 0x21 form, skip when negative
    } instr_dec_t;

    typedef enum logic [3:0] {
        ALU_PASS,  // operand straight through, lda
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_AND,
        ALU_IOR,
        ALU_NOT,
        ALU_INC,
        ALU_DEC
    } alu_op_e;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`B8_ADDR_W-1:0] adr;
        logic [`B8_DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic [`B8_DATA_W-1:0] dat_r;
        logic ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- source/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control
    import blue8_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  instr_dec_t dec,
    input  logic       acc_neg,
    input  logic       bus_done,
    output logic       bus_start,
    output logic       bus_we,
    output logic       bus_use_operand,
    output logic       ir_load,
    output logic       operand_load,
    output logic       acc_write,
    output alu_op_e    alu_op,
    output logic       pc_inc,
    output logic       pc_load,
    output logic       halted
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_MEM_RD,
        S_MEM_WR,
        S_EXEC,
        S_HALT
    } state_e;

    state_e state;
    logic   waiting;     // transfer issued, done not yet seen
    logic   bus_state;   // states that own a bus transfer
    logic   mem_rd_op;   // needs the operand word
    logic   alu_op_any;  // writes the accumulator
    logic   skip_taken;

    assign bus_state  = (state == S_FETCH) || (state == S_MEM_RD) || (state == S_MEM_WR);
    assign mem_rd_op  = dec.op_add | dec.op_sub | dec.op_xor | dec.op_and
                      | dec.op_ior | dec.op_lda;
    assign alu_op_any = mem_rd_op | dec.op_not | dec.op_inc | dec.op_dec;
    assign skip_taken = dec.op_spn && (acc_neg == dec.skip_neg);  // sign matches the form

    assign bus_start       = bus_state && !waiting;  // one pulse per state entry
    assign bus_we          = (state == S_MEM_WR);
    assign bus_use_operand = (state == S_MEM_RD) || (state == S_MEM_WR);
    assign ir_load         = (state == S_FETCH) && bus_done;
    assign operand_load    = (state == S_MEM_RD) && bus_done;
    assign acc_write       = (state == S_EXEC) && alu_op_any;
    assign pc_inc          = ir_load || ((state == S_EXEC) && skip_taken);  // fetch, then skip
    assign pc_load         = (state == S_EXEC) && dec.op_jmp;
    assign halted          = (state == S_HALT);

    always_comb begin
        alu_op = ALU_PASS;  // lda and everything else
        if (dec.op_add) alu_op = ALU_ADD;
        if (dec.op_sub) alu_op = ALU_SUB;
        if (dec.op_xor) alu_op = ALU_XOR;
        if (dec.op_and) alu_op = ALU_AND;
        if (dec.op_ior) alu_op = ALU_IOR;
        if (dec.op_not) alu_op = ALU_NOT;
        if (dec.op_inc) alu_op = ALU_INC;
        if (dec.op_dec) alu_op = ALU_DEC;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_FETCH;
            waiting <= 1'b0;
        end else begin
            if (bus_start) waiting <= 1'b1;
            else if (bus_done) waiting <= 1'b0;
            case (state)
                S_FETCH:  if (bus_done) state <= S_DECODE;
                S_DECODE: begin
                    if (dec.op_halt) state <= S_HALT;
                    else if (dec.op_sta) state <= S_MEM_WR;
                    else if (mem_rd_op) state <= S_MEM_RD;
                    else state <= S_EXEC;  // register-only and nop
                end
                S_MEM_RD: if (bus_done) state <= S_EXEC;
                S_MEM_WR: if (bus_done) state <= S_EXEC;
                S_EXEC:   state <= S_FETCH;
                default:  state <= S_HALT;  // halt is sticky until reset
            endcase
        end
    end

    // halted core must stay off the bus, nothing in flight
    a_no_start_halted: assert property (@(posedge clk) disable iff (reset)
        (state == S_HALT) |-> (!waiting && !bus_done));

endmodule

`default_nettype wire

//--- source/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module instr_decode
    import blue8_pkg::*;
(
    input  logic [`B8_DATA_W-1:0] instr,
    output instr_dec_t            dec
);

    logic [3:0] top;  // opcode nibble of memory group

    assign top = instr[`B8_DATA_W-1 -: 4];

    always_comb begin
        dec = '0;  // unknown codes fall out as all flags low
        // register-only group, full word match
        dec.op_halt = (instr == 16'h0000);
        dec.op_nop  = (instr == 16'h0001);
        dec.op_not  = (instr == 16'h0002);
        dec.op_inc  = (instr == 16'h0005);
        dec.op_dec  = (instr == 16'h0006);
        dec.op_spn  = (instr[`B8_DATA_W-1:1] == 15'h0010);  // 0x20 and 0x21
        // memory-operand group
        dec.op_add  = (top == 4'h1);
        dec.op_xor  = (top == 4'h2);
        dec.op_and  = (top == 4'h3);
        dec.op_ior  = (top == 4'h4);
        dec.op_lda  = (top[2:0] == 3'h6);  // 6xxx and Exxx both load
        dec.op_sta  = (top == 4'h7);
        dec.op_sub  = (top == 4'h9);
        dec.op_jmp  = (top == 4'hA);
        dec.operand  = instr[`B8_ADDR_W-1:0];  // address field
        dec.skip_neg = instr[0];               // low bit picks the sign
    end

endmodule

`default_nettype wire

//--- source/program_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module program_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inc,
    input  logic                  load,
    input  logic [`B8_ADDR_W-1:0] target,
    output logic [`B8_ADDR_W-1:0] pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `B8_ADDR_W'(`B8_RESET_PC);
        end else if (load) begin
            pc <= target;  // jump wins
        end else if (inc) begin
            pc <= pc + 1'b1;  // wraps at 4k
        end
    end

    // fetch increment and jump load live in different states
    a_inc_load_excl: assert property (@(posedge clk) disable iff (reset)
        !(inc && load));

endmodule

`default_nettype wire

//--- source/wb_bus_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module wb_bus_master
    import blue8_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  we,
    input  logic [`B8_ADDR_W-1:0] adr,
    input  logic [`B8_DATA_W-1:0] wdata,
    output wb_req_t               wb_out,
    input  wb_rsp_t               wb_in,
    output logic                  done,
    output logic [`B8_DATA_W-1:0] rd_data
);

    logic                  cyc;
    logic                  stb;
    logic                  we_q;
    logic [`B8_ADDR_W-1:0] adr_q;    // held for the whole cycle
    logic [`B8_DATA_W-1:0] dat_w_q;
    logic                  ack_seen;
    logic                  launch;

    assign ack_seen = cyc && wb_in.ack;
    assign launch   = start && !cyc;  // ignore start mid-cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc  <= 1'b0;
            stb  <= 1'b0;
            we_q <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= ack_seen;  // one pulse per transfer
            if (ack_seen) begin
                cyc  <= 1'b0;
                stb  <= 1'b0;
                we_q <= 1'b0;
            end else if (launch) begin
                cyc  <= 1'b1;  // cyc and stb rise together
                stb  <= 1'b1;
                we_q <= we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q   <= adr;
            dat_w_q <= wdata;
        end
        if (ack_seen && !we_q) rd_data <= wb_in.dat_r;  // capture on the ack edge
    end

    assign wb_out = '{cyc: cyc, stb: stb, we: we_q, adr: adr_q, dat_w: dat_w_q};

    // slave answers only an open strobe inside a cycle
    a_ack_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_in.ack |-> (wb_out.cyc && wb_out.stb));
    // address frozen while waiting for the slave
    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_out.stb && !wb_in.ack) |=> $stable(wb_out.adr));

endmodule

`default_nettype wire

//--- test/blue8_testdata.txt
# M addr data loads memory; E addr data is the next expected write
# A value is the final accumulator; records may share a line
# alu group with a store after each result
M 000 6100  M 001 1101  M 002 7200  M 003 9102
M 004 7201  M 005 2103  M 006 7202  M 007 3104
M 008 7203  M 009 4105  M 00A 7204  M 00B 0002
M 00C 7205  M 00D 0005  M 00E 7206  M 00F 0006
# skips on both signs then a jump over a stray store
M 010 7207  M 011 0020  M 012 7208  M 013 0002
M 014 0020  M 015 7209  M 016 0021  M 017 720A
M 018 0002  M 019 0021  M 01A 720B  M 01B A020
M 01C 720C
# jump target with wrap checks and an undefined code before halt
M 020 E106  M 021 0005  M 022 720D  M 023 0006
M 024 720E  M 025 0003  M 026 0000  M 027 720F
# operands
M 100 1234  M 101 0FF0  M 102 3000  M 103 00FF
M 104 0FF0  M 105 8001  M 106 FFFF
# expected stores in order
E 200 2224  E 201 F224  E 202 F2DB  E 203 02D0
E 204 82D1  E 205 7D2E  E 206 7D2F  E 207 7D2E
E 209 82D1  E 20B 7D2E  E 20D 0000  E 20E FFFF
A FFFF

//--- test/tb_blue8.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module tb_blue8
    import blue8_pkg::*;
();

    logic                  clk;
    logic                  reset;
    wb_req_t               wb_out;
    wb_rsp_t               wb_in;
    logic                  halted;
    logic [`B8_DATA_W-1:0] acc;
    logic                  wr_seen;
    logic [`B8_ADDR_W-1:0] wr_adr;
    logic [`B8_DATA_W-1:0] wr_dat;

    logic [`B8_ADDR_W-1:0] exp_adr [$];     // expected writes in file order
    logic [`B8_DATA_W-1:0] exp_dat [$];
    logic [`B8_DATA_W-1:0] exp_acc;
    integer                prog_len;        // words in the image
    integer                n_wr = 0;        // writes seen so far
    integer                bus_errors = 0;  // bus monitor count
    integer                run_errors;      // main sequence count
    integer                cycles;
    integer                limit;
    logic                  in_xfer = 1'b0;  // transfer open, values held
    logic                  first_seen = 1'b0;
    logic [`B8_ADDR_W-1:0] held_adr;
    logic [`B8_DATA_W-1:0] held_dat;

    blue8_core dut (
        .clk(clk), .reset(reset), .wb_out(wb_out), .wb_in(wb_in),
        .halted(halted), .acc(acc)
    );

    wb_memory_model u_mem (
        .clk(clk), .reset(reset), .wb_req(wb_out), .wb_rsp(wb_in),
        .wr_seen(wr_seen), .wr_adr(wr_adr), .wr_dat(wr_dat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic load_expectations;
        integer           fd;
        integer           n;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [8*128-1:0] rest;
        logic             at_end;
        fd = $fopen("test/blue8_testdata.txt", "r");
        at_end = 1'b0;
        if (fd == 0) begin
            $display("cannot open test/blue8_testdata.txt");
            run_errors++;
            at_end = 1'b1;
        end
        while (!at_end) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (tag == "#") begin
                n = $fgets(rest, fd);  // skip comment text
            end else if (tag == "M") begin
                n = $fscanf(fd, " %h %h", a, d);
                prog_len++;  // image size drives the cycle limit
            end else if (tag == "E") begin
                n = $fscanf(fd, " %h %h", a, d);
                exp_adr.push_back(a[`B8_ADDR_W-1:0]);
                exp_dat.push_back(d[`B8_DATA_W-1:0]);
            end else if (tag == "A") begin
                n = $fscanf(fd, " %h", d);
                exp_acc = d[`B8_DATA_W-1:0];
            end else begin
                $display("unknown record tag %c in test data", tag);
                run_errors++;
                at_end = 1'b1;
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    // bus protocol, halt and write monitor
    always @(posedge clk) begin
        if (!reset && wb_out.cyc && wb_out.stb) begin
            if (!in_xfer) begin
                in_xfer  <= 1'b1;  // first edge of a new transfer
                held_adr <= wb_out.adr;
                held_dat <= wb_out.dat_w;
                first_seen <= 1'b1;
                if (!first_seen && wb_out.adr != `B8_ADDR_W'(`B8_RESET_PC)) begin
                    $display("mismatch at %0t: first fetch from %h", $time, wb_out.adr);
                    bus_errors++;
                end
            end else if (wb_out.adr != held_adr || wb_out.dat_w != held_dat) begin
                $display("mismatch at %0t: adr or dat_w moved before ack", $time);
                bus_errors++;
            end
            if (wb_in.ack) in_xfer <= 1'b0;  // cycle closes on this edge
        end
        if (halted && wb_out.cyc) begin
            $display("bus cycle seen after halt at %0t", $time);
            bus_errors++;
        end
        if (wr_seen) begin
            if (n_wr >= exp_adr.size()) begin
                $display("unexpected write to %h at %0t", wr_adr, $time);
                bus_errors++;
            end else if (wr_adr != exp_adr[n_wr] || wr_dat != exp_dat[n_wr]) begin
                $display("mismatch at %0t: write %0d got %h=%h, expected %h=%h", $time,
                         n_wr, wr_adr, wr_dat, exp_adr[n_wr], exp_dat[n_wr]);
                bus_errors++;
            end
            n_wr = n_wr + 1;
        end
    end

    initial begin
        reset      = 1'b1;  // held from time zero
        prog_len   = 0;
        run_errors = 0;
        cycles     = 0;
        exp_acc    = '0;
        load_expectations();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);  // released, next edge not yet seen
        if (wb_out.cyc || wb_out.stb || wb_out.we || halted) begin
            $display("bus or halted not idle after reset");
            run_errors++;
        end
        if (acc != '0) begin
            $display("mismatch at %0t: acc %h after reset", $time, acc);
            run_errors++;
        end
        limit = 20 * prog_len + 4 * prog_len;  // two transfers per word, two waits each
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!halted) begin
            $display("core never halted within %0d cycles", limit);
            run_errors++;
        end else begin
            repeat (20) begin
                @(negedge clk);
                if (!halted) begin
                    $display("halted dropped at %0t", $time);
                    run_errors++;
                end
            end
            if (acc != exp_acc) begin
                $display("mismatch at %0t: final acc %h, expected %h", $time, acc, exp_acc);
                run_errors++;
            end
            if (n_wr != exp_adr.size()) begin
                $display("mismatch at %0t: %0d writes, expected %0d", $time, n_wr,
                         exp_adr.size());
                run_errors++;
            end
        end
        $display("%0d writes checked, %0d bus errors, %0d run errors", n_wr, bus_errors,
                 run_errors);
        if (bus_errors == 0 && run_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/wb_memory_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "blue8_params.svh"

module wb_memory_model
    import blue8_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    output logic                  wr_seen,  // one pulse per accepted write
    output logic [`B8_ADDR_W-1:0] wr_adr,
    output logic [`B8_DATA_W-1:0] wr_dat
);

    logic [`B8_DATA_W-1:0] mem [0:(1 << `B8_ADDR_W)-1];
    logic                  ack   = 1'b0;  // idle from time zero
    logic [`B8_DATA_W-1:0] dat_r = '0;
    logic                  busy  = 1'b0;  // transfer seen, waits counting
    integer                wait_left;     // wait states still to insert
    integer                seed = 74403;
    integer                fd;
    integer                n;
    logic [7:0]            tag;
    logic [31:0]           a;
    logic [31:0]           d;
    logic [8*128-1:0]      rest;          // tail of a comment line
    logic                  at_end;

    assign wb_rsp = '{dat_r: dat_r, ack: ack};

    initial begin
        for (int i = 0; i < (1 << `B8_ADDR_W); i++) begin
            mem[i[`B8_ADDR_W-1:0]] = {4'hF, i[`B8_ADDR_W-1:0]};  // nop words, unique per address
        end
        fd = $fopen("test/blue8_testdata.txt", "r");
        at_end = (fd == 0);  // testbench reports a missing file
        while (!at_end) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (tag == "M") begin
                n = $fscanf(fd, " %h %h", a, d);
                mem[a[`B8_ADDR_W-1:0]] = d[`B8_DATA_W-1:0];  // program or operand word
            end else if (tag == "E") begin
                n = $fscanf(fd, " %h %h", a, d);  // expected write, not for memory
            end else if (tag == "A") begin
                n = $fscanf(fd, " %h", d);
            end else begin
                n = $fgets(rest, fd);  // comment line
            end
        end
        if (fd != 0) $fclose(fd);
    end

    always @(posedge clk) begin
        wr_seen <= 1'b0;
        if (reset) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else if (ack) begin
            ack  <= 1'b0;  // master closes the cycle on this edge
            busy <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) wait_left = $unsigned($random(seed)) % 3;  // 0 to 2 waits
            busy <= 1'b1;
            if (wait_left == 0) begin
                ack <= 1'b1;
                if (wb_req.we) begin
                    mem[wb_req.adr] = wb_req.dat_w;
                    wr_seen <= 1'b1;
                    wr_adr  <= wb_req.adr;
                    wr_dat  <= wb_req.dat_w;
                end else begin
                    dat_r <= mem[wb_req.adr];  // valid together with ack
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire
